// ==== design/vload_pkg.sv ====
`default_nettype none

package vload_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and burst geometry
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W          = 32;
  localparam int DATA_W          = 64;
  localparam int BYTES_PER_BEAT  = DATA_W / 8;
  // Largest burst the master issues, in beats
  localparam int BURST_BEATS     = 16;
  // Alignment and address step between bursts
  localparam int BURST_BYTES     = BURST_BEATS * BYTES_PER_BEAT;
  localparam int MAX_OUTSTANDING = 4;

  // Beat count of a transfer lives above the byte offset of a beat
  localparam int BEAT_CNT_W  = ADDR_W - $clog2(BYTES_PER_BEAT);
  // Burst count drops the beat-within-burst bits
  localparam int BURST_CNT_W = BEAT_CNT_W - $clog2(BURST_BEATS);
  // Vacancy runs 0 .. MAX_OUTSTANDING inclusive
  localparam int VAC_CNT_W   = $clog2(MAX_OUTSTANDING + 1);

  ////////////////////////////////////////////////////////////
  // Opcodes and register map
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_VLE32 = 2'd1
  } vload_op_e;

  typedef enum logic [2:0] {
    CSR_ADDR     = 3'd0,
    CSR_LEN      = 3'd1,
    CSR_OP       = 3'd2,
    CSR_CTRL     = 3'd3,
    CSR_STATUS   = 3'd4,
    CSR_CHECKSUM = 3'd5,
    CSR_BEATS    = 3'd6
  } csr_addr_e;

  ////////////////////////////////////////////////////////////
  // Command and AXI channel payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] len;  // bytes
  } vload_cmd_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;  // beats minus one
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axi_r_t;

endpackage

`default_nettype wire

// ==== design/updown_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module updown_counter #(
  parameter int               WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  wire logic             aclk,
  input  wire logic             areset,
  input  wire logic             load,
  input  wire logic             incr,
  input  wire logic             decr,
  input  wire logic [WIDTH-1:0] load_value,
  output logic      [WIDTH-1:0] count,
  output logic                  is_zero
);

  ////////////////////////////////////////////////////////////
  // Count register
  ////////////////////////////////////////////////////////////

  // Load wins over any step
  // Incr and decr together leave the count as is
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  // Zero flag straight off the register
  assign is_zero = (count == '0);

endmodule

`default_nettype wire

// ==== design/vload_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module vload_csr import vload_pkg::*; (
  input  wire logic                  aclk,
  input  wire logic                  areset,
  // Register port
  input  wire logic                  reg_wr,
  input  wire csr_addr_e             reg_addr,
  input  wire logic [31:0]           reg_wdata,
  output logic      [31:0]           reg_rdata,
  // Command to the read master
  output logic                       start,
  output vload_cmd_t                 cmd,
  output logic                       accept_data,
  input  wire logic                  done,
  // Results from the accumulator
  input  wire logic [31:0]           checksum,
  input  wire logic [BEAT_CNT_W-1:0] beats
);

  ////////////////////////////////////////////////////////////
  // Register state
  ////////////////////////////////////////////////////////////

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] len_q;
  vload_op_e         op_q;
  logic              busy_q;
  logic              done_q;
  logic              ctrl_go;

  // Go bit written while nothing is running
  assign ctrl_go = reg_wr && (reg_addr == CSR_CTRL) && reg_wdata[0] && !busy_q;

  // Address and length of the next transfer
  always_ff @(posedge aclk) begin
    if (reg_wr && (reg_addr == CSR_ADDR)) begin
      addr_q <= reg_wdata;
    end
    if (reg_wr && (reg_addr == CSR_LEN)) begin
      len_q <= reg_wdata;
    end
  end

  // Opcode comes up as NOP
  always_ff @(posedge aclk) begin
    if (areset) begin
      op_q <= OP_NOP;
    end else if (reg_wr && (reg_addr == CSR_OP)) begin
      op_q <= vload_op_e'(reg_wdata[1:0]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Start pulse and status
  ////////////////////////////////////////////////////////////

  // Busy rises with the accepted write, so a second write one
  // cycle later already sees it
  always_ff @(posedge aclk) begin
    if (areset) begin
      start  <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      start <= ctrl_go;
      if (ctrl_go) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      // Sticky done, cleared by the next start
      if (start) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end
    end
  end

  assign cmd.addr    = addr_q;
  assign cmd.len     = len_q;
  // Read data only drains under the load opcode
  assign accept_data = (op_q == OP_VLE32);

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_addr)
      CSR_ADDR:     reg_rdata = addr_q;
      CSR_LEN:      reg_rdata = len_q;
      CSR_OP:       reg_rdata = {30'd0, op_q};
      CSR_STATUS:   reg_rdata = {30'd0, done_q, busy_q};
      CSR_CHECKSUM: reg_rdata = checksum;
      CSR_BEATS:    reg_rdata = {{(32-BEAT_CNT_W){1'b0}}, beats};
      default:      reg_rdata = 32'd0;  // CTRL reads back as zero
    endcase
  end

endmodule

`default_nettype wire

// ==== design/hbm_read_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbm_read_master import vload_pkg::*; (
  input  wire logic       aclk,
  input  wire logic       areset,
  // Command side
  input  wire logic       start,
  input  wire vload_cmd_t cmd,
  input  wire logic       accept_data,
  output logic            done,
  // AXI4 read address channel
  output logic            arvalid,
  input  wire logic       arready,
  output axi_ar_t         ar,
  // AXI4 read data channel
  input  wire logic       rvalid,
  output logic            rready,
  input  wire axi_r_t     r,
  // Accepted beats to the accumulator
  output logic            beat_valid,
  output axi_r_t          beat
);

  ////////////////////////////////////////////////////////////
  // Command latch and precompute
  ////////////////////////////////////////////////////////////

  logic [BEAT_CNT_W-1:0]            total_len_r;   // beats minus one
  logic [ADDR_W-1:0]                addr_offset_r;
  logic                             launch;
  logic [BURST_CNT_W-1:0]           num_bursts;    // bursts minus one
  logic [$clog2(BURST_BEATS)-1:0]   final_burst_len;

  // Cycle 1 after start rounds length up to whole beats and aligns the address
  always_ff @(posedge aclk) begin
    if (start) begin
      if (cmd.len[$clog2(BYTES_PER_BEAT)-1:0] != '0) begin
        total_len_r <= cmd.len[$clog2(BYTES_PER_BEAT) +: BEAT_CNT_W];
      end else begin
        total_len_r <= cmd.len[$clog2(BYTES_PER_BEAT) +: BEAT_CNT_W] - 1'b1;
      end
      addr_offset_r <= cmd.addr & ~ADDR_W'(BURST_BYTES - 1);
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      launch <= 1'b0;
    end else begin
      launch <= start;
    end
  end

  // Burst count is the upper part of the beat count
  assign num_bursts = total_len_r[$clog2(BURST_BEATS) +: BURST_CNT_W];

  // Cycle 2 latches the partial length of the final burst
  always_ff @(posedge aclk) begin
    if (launch) begin
      final_burst_len <= total_len_r[$clog2(BURST_BEATS)-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Read address channel
  ////////////////////////////////////////////////////////////

  logic                   ar_idle;
  logic                   arxfer;
  logic                   ar_final;
  logic                   stall_ar;
  logic                   rxfer;
  logic                   r_completed;
  logic [ADDR_W-1:0]      addr_r;

  assign arxfer = arvalid && arready;

  // Nothing left to issue once the last burst address is taken
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (launch) begin
      ar_idle <= 1'b0;
    end else if (ar_final && arxfer) begin
      ar_idle <= 1'b1;
    end
  end

  // Raise from low only, so every accepted address leaves a gap cycle
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (!ar_idle && !stall_ar && !arvalid) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // Next burst address
  always_ff @(posedge aclk) begin
    if (launch) begin
      addr_r <= addr_offset_r;
    end else if (arxfer) begin
      addr_r <= addr_r + ADDR_W'(BURST_BYTES);
    end
  end

  // Full bursts except the final one
  always_comb begin
    ar.addr = addr_r;
    ar.len  = ar_final ? 8'(final_burst_len) : 8'(BURST_BEATS - 1);
  end

  // Bursts still to issue with zero marking the final one
  updown_counter #(
    .WIDTH (BURST_CNT_W),
    .INIT  ('0)
  ) ar_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (launch),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (ar_final)
  );

  // Free slots for outstanding bursts
  updown_counter #(
    .WIDTH (VAC_CNT_W),
    .INIT  (VAC_CNT_W'(MAX_OUTSTANDING))
  ) vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (r_completed),
    .decr       (arxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (stall_ar)
  );

  ////////////////////////////////////////////////////////////
  // Read data channel
  ////////////////////////////////////////////////////////////

  logic                   r_final;

  // Acceptance is a plain level from the opcode
  assign rready      = accept_data;
  assign rxfer       = rvalid && rready;
  assign r_completed = rxfer && r.last;

  assign beat_valid = rxfer;
  assign beat       = r;

  // Bursts still to complete
  updown_counter #(
    .WIDTH (BURST_CNT_W),
    .INIT  ('0)
  ) r_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (launch),
    .incr       (1'b0),
    .decr       (r_completed),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (r_final)
  );

  // One cycle after the last beat of the final burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      done <= 1'b0;
    end else begin
      done <= r_completed && r_final;
    end
  end

endmodule

`default_nettype wire

// ==== design/beat_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_accumulator import vload_pkg::*; (
  input  wire logic                  aclk,
  input  wire logic                  areset,
  input  wire logic                  start,
  input  wire logic                  beat_valid,
  input  wire axi_r_t                beat,
  output logic      [31:0]           checksum,
  output logic      [BEAT_CNT_W-1:0] beats
);

  ////////////////////////////////////////////////////////////
  // Lane sum
  ////////////////////////////////////////////////////////////

  logic [31:0] lane_sum;

  // Both 32-bit lanes of the beat, wrapping
  assign lane_sum = beat.data[0 +: 32] + beat.data[32 +: 32];

  ////////////////////////////////////////////////////////////
  // Running totals
  ////////////////////////////////////////////////////////////

  // A new transfer starts from zero
  always_ff @(posedge aclk) begin
    if (areset) begin
      checksum <= '0;
      beats    <= '0;
    end else if (start) begin
      checksum <= '0;
      beats    <= '0;
    end else if (beat_valid) begin
      checksum <= checksum + lane_sum;
      beats    <= beats + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/vload_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vload_top import vload_pkg::*; (
  input  wire logic        aclk,
  input  wire logic        areset,
  // Register port
  input  wire logic        reg_wr,
  input  wire csr_addr_e   reg_addr,
  input  wire logic [31:0] reg_wdata,
  output logic      [31:0] reg_rdata,
  // AXI4 read address channel
  output logic             arvalid,
  input  wire logic        arready,
  output axi_ar_t          ar,
  // AXI4 read data channel
  input  wire logic        rvalid,
  output logic             rready,
  input  wire axi_r_t      r
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  logic                  start;
  logic                  done;
  logic                  accept_data;
  vload_cmd_t            cmd;
  logic                  beat_valid;
  axi_r_t                beat;
  logic [31:0]           checksum;
  logic [BEAT_CNT_W-1:0] beats;

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  vload_csr csr0 (
    .aclk        (aclk),
    .areset      (areset),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .start       (start),
    .cmd         (cmd),
    .accept_data (accept_data),
    .done        (done),
    .checksum    (checksum),
    .beats       (beats)
  );

  hbm_read_master master0 (
    .aclk        (aclk),
    .areset      (areset),
    .start       (start),
    .cmd         (cmd),
    .accept_data (accept_data),
    .done        (done),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar          (ar),
    .rvalid      (rvalid),
    .rready      (rready),
    .r           (r),
    .beat_valid  (beat_valid),
    .beat        (beat)
  );

  // Folds every accepted beat into the checksum
  beat_accumulator acc0 (
    .aclk       (aclk),
    .areset     (areset),
    .start      (start),
    .beat_valid (beat_valid),
    .beat       (beat),
    .checksum   (checksum),
    .beats      (beats)
  );

endmodule

`default_nettype wire

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import vload_pkg::*; (
  input  wire logic    aclk,
  input  wire logic    areset,
  // Long wait before the first beat of each burst
  input  wire logic    slow,
  // AXI4 read address channel
  input  wire logic    arvalid,
  output logic         arready,
  input  wire axi_ar_t ar,
  // AXI4 read data channel
  output logic         rvalid,
  input  wire logic    rready,
  output axi_r_t       r,
  // Traffic statistics
  output int           ar_count,
  output int           bursts_done,
  output int           out_max
);

  ////////////////////////////////////////////////////////////
  // Model state
  ////////////////////////////////////////////////////////////

  localparam int SEED      = 32'h6d62;
  localparam int LOG_DEPTH = 128;
  localparam int SLOW_GAP  = 32;

  // Every accepted AR, in order; also the queue of bursts to serve
  logic [ADDR_W-1:0] ar_addr_log [LOG_DEPTH];
  logic [7:0]        ar_len_log  [LOG_DEPTH];
  logic [ADDR_W-1:0] beat_addr;
  integer            seed;
  int                out_now;
  int                serve_idx;
  int                beat_idx;
  int                gap;
  logic              armed;

  // Each 32-bit word holds its byte address over 4, plus 0x100
  function automatic logic [31:0] word_at(input logic [ADDR_W-1:0] byte_addr);
    return (byte_addr >> 2) + 32'h100;
  endfunction

  initial begin
    seed    = SEED;
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
  end

  ////////////////////////////////////////////////////////////
  // Channel behavior
  ////////////////////////////////////////////////////////////

  // Handshakes are sampled at the edge, outputs change 1 ns later
  always @(posedge aclk) begin
    if (areset) begin
      ar_count    = 0;
      bursts_done = 0;
      out_now     = 0;
      out_max     = 0;
      serve_idx   = 0;
      beat_idx    = 0;
      gap         = 0;
      armed       = 1'b0;
      #1;
      arready = 1'b0;
      rvalid  = 1'b0;
      r       = '0;
    end else begin
      if (arvalid && arready) begin
        ar_addr_log[ar_count] = ar.addr;
        ar_len_log[ar_count]  = ar.len;
        ar_count++;
        out_now++;
        if (out_now > out_max) begin
          out_max = out_now;
        end
      end
      if (rvalid && rready) begin
        armed = 1'b0;
        if (r.last) begin
          serve_idx++;
          beat_idx = 0;
          bursts_done++;
          out_now--;
        end else begin
          beat_idx++;
        end
      end
      // Pick a gap for the next beat once a burst is pending
      if (!armed && serve_idx < ar_count) begin
        armed = 1'b1;
        if (slow && beat_idx == 0) begin
          gap = SLOW_GAP + ($random(seed) & 7);
        end else begin
          gap = $random(seed) & 3;
        end
      end else if (armed && gap > 0) begin
        gap--;
      end
      #1;
      // Address back-pressure about one cycle in four
      arready = ($random(seed) & 3) != 0;
      rvalid  = armed && gap == 0;
      if (rvalid) begin
        beat_addr = ar_addr_log[serve_idx] + ADDR_W'(beat_idx * BYTES_PER_BEAT);
        r.data    = {word_at(beat_addr + 4), word_at(beat_addr)};
        r.last    = (beat_idx == int'(ar_len_log[serve_idx]));
      end else begin
        r = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_vload_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vload_top import vload_pkg::*; ();

  ////////////////////////////////////////////////////////////
  // Run limits and signals
  ////////////////////////////////////////////////////////////

  localparam int CLK_HALF = 4;
  // Slow test is the longest at 16 bursts of roughly 80 cycles
  // Other tests and the 200-cycle NOP watch add well under 1000
  localparam int TIMEOUT_CYCLES = 4000;

  logic        aclk;
  logic        areset;
  logic        reg_wr;
  csr_addr_e   reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        arvalid;
  logic        arready;
  axi_ar_t     ar;
  logic        rvalid;
  logic        rready;
  axi_r_t      r;
  logic        slow;
  int          ar_count;
  int          bursts_done;
  int          out_max;
  int          test_errors;
  int          pass_count;
  int          fail_count;
  int          cycles;

  vload_top dut0 (
    .aclk      (aclk),
    .areset    (areset),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .arvalid   (arvalid),
    .arready   (arready),
    .ar        (ar),
    .rvalid    (rvalid),
    .rready    (rready),
    .r         (r)
  );

  axi_mem_model mem0 (
    .aclk        (aclk),
    .areset      (areset),
    .slow        (slow),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar          (ar),
    .rvalid      (rvalid),
    .rready      (rready),
    .r           (r),
    .ar_count    (ar_count),
    .bursts_done (bursts_done),
    .out_max     (out_max)
  );

  initial begin
    aclk = 1'b0;
    forever #CLK_HALF aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return (byte_addr >> 2) + 32'h100;
  endfunction

  // Length rounded up to whole 8-byte beats
  function automatic int beats_for(input logic [31:0] len_bytes);
    return (len_bytes + 7) / 8;
  endfunction

  // Two words per beat counted from the 128-byte aligned address
  function automatic logic [31:0] expected_sum(input logic [31:0] addr, input int beats);
    logic [31:0] base;
    logic [31:0] sum;
    base = addr & ~32'd127;
    sum  = '0;
    for (int i = 0; i < 2 * beats; i++) begin
      sum = sum + mem_word(base + 32'(4 * i));
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus and check tasks
  ////////////////////////////////////////////////////////////

  task automatic reset_dut();
    @(posedge aclk);
    #1;
    areset = 1'b1;
    repeat (5) @(posedge aclk);
    #1;
    areset = 1'b0;
  endtask

  task automatic write_reg(input csr_addr_e addr, input logic [31:0] data);
    @(posedge aclk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge aclk);
    #1;
    reg_wr = 1'b0;
  endtask

  // Readback is combinational, sampled mid-cycle
  task automatic read_reg(input csr_addr_e addr, output logic [31:0] data);
    @(posedge aclk);
    #1;
    reg_addr = addr;
    @(negedge aclk);
    data = reg_rdata;
  endtask

  // Returns once the old sticky done bit has been cleared by start
  task automatic start_transfer(input logic [31:0] addr, input logic [31:0] len);
    write_reg(CSR_ADDR, addr);
    write_reg(CSR_LEN, len);
    write_reg(CSR_CTRL, 32'h1);
    @(posedge aclk);
    #1;
  endtask

  task automatic wait_done();
    reg_addr = CSR_STATUS;
    @(negedge aclk);
    while (!reg_rdata[1]) @(negedge aclk);
  endtask

  task automatic check_equal(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s %s expected 0x%08h actual 0x%08h",
               test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string test_name);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", test_name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  // Runs one transfer and checks AR log and beat count against the burst rules
  task automatic run_load(input string test_name, input logic [31:0] addr,
                          input logic [31:0] len, output logic [31:0] sum);
    int          base;
    int          beats;
    int          bursts;
    logic [31:0] value;
    base   = ar_count;
    beats  = beats_for(len);
    bursts = (beats + 15) / 16;
    start_transfer(addr, len);
    wait_done();
    check_equal(test_name, "AR count", bursts, ar_count - base);
    for (int j = 0; j < bursts; j++) begin
      check_equal(test_name, "AR addr", (addr & ~32'd127) + 32'(128 * j),
                  mem0.ar_addr_log[base + j]);
      check_equal(test_name, "AR len", (j == bursts - 1) ? (beats - 1) % 16 : 15,
                  mem0.ar_len_log[base + j]);
    end
    read_reg(CSR_BEATS, value);
    check_equal(test_name, "beats", beats, value);
    read_reg(CSR_CHECKSUM, sum);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] value;
    logic [31:0] sum_single;
    logic [31:0] sum_multi;
    int          base;
    int          done_base;
    logic        saw_rready;
    logic        saw_done;
    areset      = 1'b1;
    reg_wr      = 1'b0;
    reg_addr    = CSR_ADDR;
    reg_wdata   = '0;
    slow        = 1'b0;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    reset_dut();
    write_reg(CSR_OP, 32'(OP_VLE32));

    run_load("single_burst", 32'h1000, 32'd40, sum_single);
    finish_test("single_burst");
    run_load("multi_burst", 32'h2050, 32'd300, sum_multi);
    finish_test("multi_burst");
    check_equal("checksum", "single sum", expected_sum(32'h1000, 5), sum_single);
    check_equal("checksum", "multi sum", expected_sum(32'h2050, 38), sum_multi);
    finish_test("checksum");

    // Slow data keeps the vacancy counter at zero
    @(posedge aclk);
    #1;
    slow      = 1'b1;
    base      = ar_count;
    done_base = bursts_done;
    start_transfer(32'h8000, 32'd2048);
    wait_done();
    check_equal("outstanding", "bursts done", 32'd16, bursts_done - done_base);
    check_equal("outstanding", "AR count", 32'd16, ar_count - base);
    assert (out_max <= MAX_OUTSTANDING) else begin
      $display("[ERROR] outstanding peak expected at most %0d actual %0d",
               MAX_OUTSTANDING, out_max);
      test_errors++;
    end
    read_reg(CSR_BEATS, value);
    check_equal("outstanding", "beats", 32'd256, value);
    #1;
    slow = 1'b0;
    finish_test("outstanding");

    // Second CTRL write lands while busy once the first AR is taken
    base = ar_count;
    start_transfer(32'h3000, 32'd256);
    read_reg(CSR_STATUS, value);
    check_equal("status", "STATUS busy", 32'h1, value);
    while (ar_count == base) @(negedge aclk);
    write_reg(CSR_CTRL, 32'h1);
    wait_done();
    read_reg(CSR_STATUS, value);
    check_equal("status", "STATUS done", 32'h2, value);
    read_reg(CSR_BEATS, value);
    check_equal("status", "beats", 32'd32, value);
    check_equal("status", "AR count", 32'd2, ar_count - base);
    finish_test("status");

    // Opcode is NOP after reset, so data is never accepted
    reset_dut();
    start_transfer(32'h5000, 32'd64);
    @(negedge aclk);
    while (ar_count == 0) @(negedge aclk);
    @(posedge aclk);
    #1;
    reg_addr   = CSR_STATUS;
    saw_rready = 1'b0;
    saw_done   = 1'b0;
    repeat (200) begin
      @(negedge aclk);
      saw_rready = saw_rready | rready;
      saw_done   = saw_done | reg_rdata[1];
    end
    check_equal("nop_hold", "rready seen", 32'd0, saw_rready);
    check_equal("nop_hold", "done seen", 32'd0, saw_done);
    check_equal("nop_hold", "busy", 32'd1, reg_rdata[0]);
    finish_test("nop_hold");

    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cycles++;
    end
    $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/vload_pkg.sv
design/updown_counter.sv
design/vload_csr.sv
design/hbm_read_master.sv
design/beat_accumulator.sv
design/vload_top.sv
verif/axi_mem_model.sv
verif/tb_vload_top.sv

// ==== Bender.yml ====
package:
  name: vload_unit

sources:
  # Design sources, package first
  - target: any(rtl, simulation, test)
    files:
      - design/vload_pkg.sv
      - design/updown_counter.sv
      - design/vload_csr.sv
      - design/hbm_read_master.sv
      - design/beat_accumulator.sv
      - design/vload_top.sv

  # Testbench and AXI slave model
  - target: any(simulation, test)
    files:
      - verif/axi_mem_model.sv
      - verif/tb_vload_top.sv
